/* Bender.yml */
package:
  name: main_xbar

sources:
  - files:
      - design/platform_pkg.sv
      - design/wb_addr_decoder.sv
      - design/wb_scratch_slave.sv
      - design/wb_resp_mux.sv
      - design/main_xbar.sv

  - target: test
    files:
      - bench/main_xbar_assertions.sv
      - bench/main_xbar_tb.sv

/* bench/main_xbar_assertions.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// master-side wishbone protocol assertions for the crossbar
//////////////////////////////////////////////////////////////////////
module main_xbar_assertions (
    input logic clk_i,
    input logic i_rst_n,
    input logic i_cyc,
    input logic i_stb,
    input logic i_stall,
    input logic i_ack,
    input logic i_err
);

    // read by the testbench at the end of the run
    int unsigned fail_cnt = 0;

    // only one kind of answer per cycle
    ack_err_excl: assert property (@(posedge clk_i) disable iff (!i_rst_n)
        !(i_ack && i_err))
    else begin
        fail_cnt++;
        $error("ack and err high in the same cycle");
    end

    // each answer belongs to a request taken the cycle before
    resp_has_req: assert property (@(posedge clk_i) disable iff (!i_rst_n)
        (i_ack || i_err) |-> $past(i_cyc && i_stb && !i_stall))
    else begin
        fail_cnt++;
        $error("response without a request accepted in the previous cycle");
    end

    // bus free as soon as reset lets go
    stall_after_rst: assert property (@(posedge clk_i)
        $rose(i_rst_n) |-> !i_stall)
    else begin
        fail_cnt++;
        $error("stall high right after reset");
    end

endmodule : main_xbar_assertions

/* bench/main_xbar_tb.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// testbench for the peripheral crossbar, random wishbone traffic
// checked against a register model
//////////////////////////////////////////////////////////////////////
module main_xbar_tb;

    localparam int AW       = platform_pkg::MAIN_WB_AW;
    localparam int DW       = platform_pkg::MAIN_WB_DW;
    localparam int SW       = platform_pkg::MAIN_WB_SW;
    localparam int NS       = platform_pkg::MAIN_XBAR_NUM_SLAVES;
    localparam int SPAN     = platform_pkg::MAIN_XBAR_SLAVE_SPAN;
    localparam int RAW      = platform_pkg::MAIN_XBAR_REG_AW;
    localparam int NW       = 2 ** RAW;
    localparam int WAIT_MAX = 20;

    logic          clk_i;
    logic          i_rst_n;
    logic          i_cyc;
    logic          i_stb;
    logic          i_we;
    logic [AW-1:0] i_addr;
    logic [DW-1:0] i_wdata;
    logic [SW-1:0] i_sel;
    logic          o_stall;
    logic          o_ack;
    logic [DW-1:0] o_rdata;
    logic          o_err;

    // register model, word 0 of each slave holds its index
    logic [DW-1:0] model [NS][NW];

    // expected answers in acceptance order
    logic          exp_err_q  [$];
    logic [DW-1:0] exp_data_q [$];
    int unsigned   acc_cyc_q  [$];

    // what was accepted in the previous cycle
    logic          prev_acc;
    logic          prev_unmapped;
    int unsigned   prev_slv;

    int unsigned   cyc_cnt;
    int unsigned   err_cnt;
    int unsigned   chk_cnt;
    int unsigned   test_cnt;
    int unsigned   err_base;
    int unsigned   chk_base;

    main_xbar main_xbar_i (
        .clk_i  (clk_i),
        .i_rst_n(i_rst_n),
        .i_cyc  (i_cyc),
        .i_stb  (i_stb),
        .i_we   (i_we),
        .i_addr (i_addr),
        .i_wdata(i_wdata),
        .i_sel  (i_sel),
        .o_stall(o_stall),
        .o_ack  (o_ack),
        .o_rdata(o_rdata),
        .o_err  (o_err)
    );

    bind main_xbar main_xbar_assertions main_xbar_assertions_i (
        .clk_i  (clk_i),
        .i_rst_n(i_rst_n),
        .i_cyc  (i_cyc),
        .i_stb  (i_stb),
        .i_stall(o_stall),
        .i_ack  (o_ack),
        .i_err  (o_err)
    );

    always #20 clk_i = ~clk_i;

    task automatic abort_run(input string why);
        $display("timeout: %s at cycle %0d", why, cyc_cnt);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic check_rdata(input string name, input logic [DW-1:0] got,
                               input logic [DW-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cyc_cnt);
        end
    endtask

    task automatic check_resp_kind(input string name, input logic got_ack,
                                   input logic got_err, input logic exp_err);
        chk_cnt++;
        if (got_ack !== !exp_err || got_err !== exp_err) begin
            err_cnt++;
            $display("ERR %s ack 0x%h err 0x%h expected ack 0x%h err 0x%h at cycle %0d",
                     name, got_ack, got_err, !exp_err, exp_err, cyc_cnt);
        end
    endtask

    task automatic check_stall(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cyc_cnt);
        end
    endtask

    function automatic logic [AW-1:0] slave_addr(input int unsigned slv, input int unsigned word);
        return (AW'(slv) << SPAN) | (AW'(word) << 2);
    endfunction

    // anything whose bits above the span reach past the last slave
    function automatic logic [AW-1:0] unmapped_addr();
        logic [AW-1:0] a;
        a = $urandom;
        if (a[AW-1:SPAN] < NS) begin
            a[AW-1] = 1'b1;
        end
        return a;
    endfunction

    // an error answer blocks everything, a pending slave blocks other targets
    function automatic logic expected_stall(input logic stb, input logic [AW-1:0] addr);
        int unsigned slv;
        slv = addr[AW-1:SPAN];
        if (prev_acc && prev_unmapped) begin
            return 1'b1;
        end
        if (stb && prev_acc && (slv >= NS || slv != prev_slv)) begin
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // expected answer from the model at the moment of acceptance
    task automatic record_accept(input logic we, input logic [AW-1:0] addr,
                                 input logic [DW-1:0] wdata, input logic [SW-1:0] sel);
        int unsigned slv;
        int unsigned word;
        slv  = addr[AW-1:SPAN];
        word = addr[RAW+1:2];
        acc_cyc_q.push_back(cyc_cnt);
        if (slv >= NS) begin
            exp_err_q.push_back(1'b1);
            exp_data_q.push_back('0);
        end else if (we) begin
            exp_err_q.push_back(1'b0);
            exp_data_q.push_back('0);
            if (word != 0) begin
                for (int b = 0; b < SW; b++) begin
                    if (sel[b]) begin
                        model[slv][word][8*b +: 8] = wdata[8*b +: 8];
                    end
                end
            end
        end else begin
            exp_err_q.push_back(1'b0);
            exp_data_q.push_back(model[slv][word]);
        end
    endtask

    // every answer must come exactly one cycle after its acceptance
    task automatic collect_responses();
        logic resp;
        resp = (o_ack === 1'b1) || (o_err === 1'b1);
        if (resp && acc_cyc_q.size() == 0) begin
            err_cnt++;
            $display("response at cycle %0d with no request outstanding", cyc_cnt);
        end else if (resp) begin
            if (acc_cyc_q[0] + 1 != cyc_cnt) begin
                err_cnt++;
                $display("response at cycle %0d for a request accepted at cycle %0d",
                         cyc_cnt, acc_cyc_q[0]);
            end
            check_resp_kind("o_ack/o_err", o_ack, o_err, exp_err_q[0]);
            if (!exp_err_q[0]) begin
                check_rdata("o_rdata", o_rdata, exp_data_q[0]);
            end
            void'(acc_cyc_q.pop_front());
            void'(exp_err_q.pop_front());
            void'(exp_data_q.pop_front());
        end else if (acc_cyc_q.size() != 0 && acc_cyc_q[0] < cyc_cnt) begin
            err_cnt++;
            $display("no response at cycle %0d for the request accepted at cycle %0d",
                     cyc_cnt, acc_cyc_q[0]);
            void'(acc_cyc_q.pop_front());
            void'(exp_err_q.pop_front());
            void'(exp_data_q.pop_front());
        end
    endtask

    // drive after the edge, sample in the middle of the cycle
    task automatic step_cycle(input logic stb, input logic we, input logic [AW-1:0] addr,
                              input logic [DW-1:0] wdata, input logic [SW-1:0] sel,
                              output logic accepted);
        @(posedge clk_i);
        #2;
        i_stb   = stb;
        i_we    = we;
        i_addr  = addr;
        i_wdata = wdata;
        i_sel   = sel;
        @(negedge clk_i);
        cyc_cnt++;
        collect_responses();
        check_stall("o_stall", o_stall, expected_stall(stb, addr));
        accepted = i_cyc && stb && (o_stall === 1'b0);
        if (accepted) begin
            record_accept(we, addr, wdata, sel);
        end
        prev_acc      = accepted;
        prev_unmapped = (addr[AW-1:SPAN] >= NS);
        prev_slv      = addr[AW-1:SPAN];
    endtask

    // stb stays high on return so calls run back to back
    task automatic bus_access(input logic we, input logic [AW-1:0] addr,
                              input logic [DW-1:0] wdata, input logic [SW-1:0] sel);
        logic        acc;
        int unsigned tries;
        acc   = 1'b0;
        tries = 0;
        while (!acc && tries < WAIT_MAX) begin
            step_cycle(1'b1, we, addr, wdata, sel, acc);
            tries++;
        end
        if (!acc) begin
            abort_run("request never accepted");
        end
    endtask

    task automatic drain_responses();
        logic        acc;
        int unsigned tries;
        tries = 0;
        do begin
            step_cycle(1'b0, 1'b0, '0, '0, '0, acc);
            tries++;
        end while (acc_cyc_q.size() != 0 && tries < WAIT_MAX);
        if (acc_cyc_q.size() != 0) begin
            abort_run("responses still outstanding");
        end
    endtask

    task automatic sweep_readback();
        for (int s = 0; s < NS; s++) begin
            for (int w = 0; w < NW; w++) begin
                bus_access(1'b0, slave_addr(s, w), '0, '0);
            end
        end
        drain_responses();
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("test %0d %s: %0d checks, %0d errors", test_cnt, name,
                 chk_cnt - chk_base, err_cnt - err_base);
        chk_base = chk_cnt;
        err_base = err_cnt;
    endtask

    initial begin
        int unsigned slv;
        int unsigned asrt_fail;
        clk_i         = 1'b0;
        i_rst_n       = 1'b0;
        i_cyc         = 1'b0;
        i_stb         = 1'b0;
        i_we          = 1'b0;
        i_addr        = '0;
        i_wdata       = '0;
        i_sel         = '0;
        prev_acc      = 1'b0;
        prev_unmapped = 1'b0;
        prev_slv      = 0;
        cyc_cnt       = 0;
        err_cnt       = 0;
        chk_cnt       = 0;
        test_cnt      = 0;
        err_base      = 0;
        chk_base      = 0;
        void'($urandom(32'h25e9_c3ef));
        for (int s = 0; s < NS; s++) begin
            for (int w = 0; w < NW; w++) begin
                model[s][w] = (w == 0) ? DW'(s) : '0;
            end
        end
        repeat (16) @(posedge clk_i);
        #2;
        i_rst_n = 1'b1;
        i_cyc   = 1'b1;

        // full words into every slave, then read them back
        for (int s = 0; s < NS; s++) begin
            for (int w = 1; w < NW; w++) begin
                bus_access(1'b1, slave_addr(s, w), $urandom, {SW{1'b1}});
            end
            for (int w = 1; w < NW; w++) begin
                bus_access(1'b0, slave_addr(s, w), '0, '0);
            end
        end
        drain_responses();
        finish_test("write and read back");

        for (int n = 0; n < 48; n++) begin
            slv = $urandom_range(NS - 1);
            bus_access(1'b1, slave_addr(slv, $urandom_range(NW - 1, 1)), $urandom, SW'($urandom));
            bus_access(1'b0, slave_addr(slv, $urandom_range(NW - 1, 1)), '0, '0);
        end
        drain_responses();
        finish_test("byte enables");

        // id word before and after a write attempt
        for (int s = 0; s < NS; s++) begin
            bus_access(1'b0, slave_addr(s, 0), '0, '0);
            bus_access(1'b1, slave_addr(s, 0), $urandom, {SW{1'b1}});
            bus_access(1'b0, slave_addr(s, 0), '0, '0);
        end
        drain_responses();
        finish_test("identity word");

        bus_access(1'b1, slave_addr(NS, 1), $urandom, {SW{1'b1}});
        for (int n = 0; n < 16; n++) begin
            bus_access(n[0], unmapped_addr(), $urandom, SW'($urandom));
        end
        drain_responses();
        sweep_readback();
        finish_test("unmapped addresses");

        // mixed traffic with stb held across slave switches
        for (int n = 0; n < 200; n++) begin
            if ($urandom_range(7) == 0) begin
                bus_access($urandom_range(1), unmapped_addr(), $urandom, SW'($urandom));
            end else begin
                bus_access($urandom_range(1),
                           slave_addr($urandom_range(NS - 1), $urandom_range(NW - 1)),
                           $urandom, SW'($urandom));
            end
        end
        drain_responses();
        sweep_readback();
        finish_test("back-to-back traffic");

        asrt_fail = main_xbar_i.main_xbar_assertions_i.fail_cnt;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_cnt, chk_cnt, err_cnt, asrt_fail);
        if (err_cnt == 0 && asrt_fail == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : main_xbar_tb

/* build.f */
design/platform_pkg.sv
design/wb_addr_decoder.sv
design/wb_scratch_slave.sv
design/wb_resp_mux.sv
design/main_xbar.sv
bench/main_xbar_assertions.sv
bench/main_xbar_tb.sv

/* design/main_xbar.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// main crossbar, one wishbone master fanned out to scratch slaves
//////////////////////////////////////////////////////////////////////
module main_xbar #(
    parameter int NUM_SLAVES = platform_pkg::MAIN_XBAR_NUM_SLAVES,
    parameter int SPAN_LG2   = platform_pkg::MAIN_XBAR_SLAVE_SPAN,
    parameter int REG_AW     = platform_pkg::MAIN_XBAR_REG_AW
) (
    input  logic                                clk_i,
    input  logic                                i_rst_n,

    // master bus
    input  logic                                i_cyc,
    input  logic                                i_stb,
    input  logic                                i_we,
    input  logic [platform_pkg::MAIN_WB_AW-1:0] i_addr,
    input  logic [platform_pkg::MAIN_WB_DW-1:0] i_wdata,
    input  logic [platform_pkg::MAIN_WB_SW-1:0] i_sel,
    output logic                                o_stall,
    output logic                                o_ack,
    output logic [platform_pkg::MAIN_WB_DW-1:0] o_rdata,
    output logic                                o_err
);

    localparam int DW = platform_pkg::MAIN_WB_DW;

    logic [NUM_SLAVES-1:0]    slv_stb;
    logic [NUM_SLAVES-1:0]    slv_ack;
    logic [NUM_SLAVES*DW-1:0] slv_rdata;
    logic                     dec_err;
    logic                     resp_valid;

    // bank must fit inside the slave window
    if (REG_AW + 2 > SPAN_LG2) begin : gen_span_check
        $error("REG_AW does not fit inside the slave span");
    end

    wb_addr_decoder #(
        .NUM_SLAVES(NUM_SLAVES),
        .SPAN_LG2  (SPAN_LG2)
    ) wb_addr_decoder_i (
        .clk_i       (clk_i),
        .i_rst_n     (i_rst_n),
        .i_cyc       (i_cyc),
        .i_stb       (i_stb),
        .i_addr      (i_addr),
        .i_resp_valid(resp_valid),
        .o_stall     (o_stall),
        .o_slv_stb   (slv_stb),
        .o_dec_err   (dec_err)
    );

    // word index sits above the two byte bits
    for (genvar i = 0; i < NUM_SLAVES; i++) begin : gen_slaves
        wb_scratch_slave #(
            .SLAVE_IDX(i),
            .REG_AW   (REG_AW)
        ) wb_scratch_slave_i (
            .clk_i  (clk_i),
            .i_rst_n(i_rst_n),
            .i_stb  (slv_stb[i]),
            .i_we   (i_we),
            .i_addr (i_addr[REG_AW+1:2]),
            .i_wdata(i_wdata),
            .i_sel  (i_sel),
            .o_ack  (slv_ack[i]),
            .o_rdata(slv_rdata[i*DW +: DW])
        );
    end

    wb_resp_mux #(
        .NUM_SLAVES(NUM_SLAVES)
    ) wb_resp_mux_i (
        .i_slv_ack   (slv_ack),
        .i_slv_rdata (slv_rdata),
        .i_dec_err   (dec_err),
        .o_ack       (o_ack),
        .o_err       (o_err),
        .o_rdata     (o_rdata),
        .o_resp_valid(resp_valid)
    );

endmodule : main_xbar

/* design/platform_pkg.sv */
//////////////////////////////////////////////////////////////////////
// platform package with bus widths, address map defaults and the
// decoder state type shared by the peripheral crossbar
//////////////////////////////////////////////////////////////////////
package platform_pkg;

    // wishbone byte address width
    localparam int MAIN_WB_AW = 32;

    // wishbone data width, one word
    localparam int MAIN_WB_DW = 32;

    // one select bit per byte lane
    localparam int MAIN_WB_SW = MAIN_WB_DW / 8;

    // number of peripheral slaves behind the crossbar
    localparam int MAIN_XBAR_NUM_SLAVES = 4;

    // log2 of each slave's byte window
    // slave i owns the addresses whose bits above the span equal i,
    // anything past the last slave is unmapped
    localparam int MAIN_XBAR_SLAVE_SPAN = 8;

    // log2 of words per slave register bank, must fit in the span
    localparam int MAIN_XBAR_REG_AW = 4;

    // decoder states
    typedef enum logic [1:0] {
        // nothing outstanding
        IDLE     = 2'd0,
        // responses from the current slave are pending
        BUSY     = 2'd1,
        // error answer goes out on the next cycle
        ERR_RESP = 2'd2
    } dec_state_e;

endpackage : platform_pkg

/* design/wb_addr_decoder.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// wishbone address decoder, routes strobes to one slave and answers
// unmapped requests with a bus error
//////////////////////////////////////////////////////////////////////
module wb_addr_decoder #(
    parameter int NUM_SLAVES = platform_pkg::MAIN_XBAR_NUM_SLAVES,
    parameter int SPAN_LG2   = platform_pkg::MAIN_XBAR_SLAVE_SPAN
) (
    input  logic                                clk_i,
    input  logic                                i_rst_n,
    input  logic                                i_cyc,
    input  logic                                i_stb,
    input  logic [platform_pkg::MAIN_WB_AW-1:0] i_addr,
    input  logic                                i_resp_valid,
    output logic                                o_stall,
    output logic [NUM_SLAVES-1:0]               o_slv_stb,
    output logic                                o_dec_err
);

    localparam int IDXW = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;
    localparam int TGTW = platform_pkg::MAIN_WB_AW - SPAN_LG2;
    localparam int CNTW = 2;

    platform_pkg::dec_state_e state;
    platform_pkg::dec_state_e state_nxt;
    logic [CNTW-1:0]          out_cnt;
    logic [CNTW-1:0]          out_cnt_nxt;
    logic [IDXW-1:0]          cur_tgt;
    logic [TGTW-1:0]          tgt_full;
    logic [IDXW-1:0]          tgt_idx;
    logic                     mapped;
    logic                     accept;

    // target slave from the bits above the window
    assign tgt_full = i_addr[platform_pkg::MAIN_WB_AW-1:SPAN_LG2];
    assign tgt_idx  = tgt_full[IDXW-1:0];
    assign mapped   = (tgt_full < NUM_SLAVES);

    // hold off anything that would mix slaves or overlap an error
    always_comb begin
        o_stall = 1'b0;
        if (state == platform_pkg::ERR_RESP) begin
            o_stall = 1'b1;
        end else if (state == platform_pkg::BUSY && i_stb) begin
            o_stall = !mapped || (tgt_idx != cur_tgt);
        end
    end

    assign accept    = i_cyc && i_stb && !o_stall;
    assign o_slv_stb = (accept && mapped) ? (NUM_SLAVES'(1) << tgt_idx) : '0;
    assign o_dec_err = (state == platform_pkg::ERR_RESP);

    always_comb begin
        out_cnt_nxt = out_cnt + CNTW'(accept) - CNTW'(i_resp_valid);
        state_nxt   = state;
        if (accept) begin
            state_nxt = mapped ? platform_pkg::BUSY : platform_pkg::ERR_RESP;
        end else if (out_cnt_nxt == '0) begin
            state_nxt = platform_pkg::IDLE;
        end
    end

    // dropping cyc forgets all outstanding traffic
    always_ff @(posedge clk_i) begin
        if (!i_rst_n || !i_cyc) begin
            state   <= platform_pkg::IDLE;
            out_cnt <= '0;
        end else begin
            state   <= state_nxt;
            out_cnt <= out_cnt_nxt;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && mapped) begin
            cur_tgt <= tgt_idx;
        end
    end

endmodule : wb_addr_decoder

/* design/wb_resp_mux.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// response merger, folds slave acks and data with the decoder error
//////////////////////////////////////////////////////////////////////
module wb_resp_mux #(
    parameter int NUM_SLAVES = platform_pkg::MAIN_XBAR_NUM_SLAVES
) (
    input  logic [NUM_SLAVES-1:0]                           i_slv_ack,
    input  logic [NUM_SLAVES*platform_pkg::MAIN_WB_DW-1:0]  i_slv_rdata,
    input  logic                                            i_dec_err,
    output logic                                            o_ack,
    output logic                                            o_err,
    output logic [platform_pkg::MAIN_WB_DW-1:0]             o_rdata,
    output logic                                            o_resp_valid
);

    localparam int DW = platform_pkg::MAIN_WB_DW;

    assign o_ack = |i_slv_ack;

    // at most one slave acks per cycle so and-or is enough
    always_comb begin
        o_rdata = '0;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            o_rdata = o_rdata | ({DW{i_slv_ack[s]}} & i_slv_rdata[s*DW +: DW]);
        end
    end

    // decoder error goes straight out
    assign o_err = i_dec_err;

    // counted down by the decoder
    assign o_resp_valid = o_ack || i_dec_err;

endmodule : wb_resp_mux

/* design/wb_scratch_slave.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// scratch register slave with byte writes and a read-only id word
//////////////////////////////////////////////////////////////////////
module wb_scratch_slave #(
    parameter int SLAVE_IDX = 0,
    parameter int REG_AW    = platform_pkg::MAIN_XBAR_REG_AW
) (
    input  logic                                clk_i,
    input  logic                                i_rst_n,
    input  logic                                i_stb,
    input  logic                                i_we,
    input  logic [REG_AW-1:0]                   i_addr,
    input  logic [platform_pkg::MAIN_WB_DW-1:0] i_wdata,
    input  logic [platform_pkg::MAIN_WB_SW-1:0] i_sel,
    output logic                                o_ack,
    output logic [platform_pkg::MAIN_WB_DW-1:0] o_rdata
);

    localparam int NUM_WORDS = 2 ** REG_AW;

    logic [platform_pkg::MAIN_WB_DW-1:0] regs [NUM_WORDS];
    logic [platform_pkg::MAIN_WB_DW-1:0] rd_word;

    // word 0 is the identity register
    assign rd_word = (i_addr == '0) ? platform_pkg::MAIN_WB_DW'(SLAVE_IDX) : regs[i_addr];

    // register bank, writes to word 0 are dropped
    always_ff @(posedge clk_i) begin
        if (!i_rst_n) begin
            for (int w = 0; w < NUM_WORDS; w++) begin
                regs[w] <= '0;
            end
        end else if (i_stb && i_we && (i_addr != '0)) begin
            for (int b = 0; b < platform_pkg::MAIN_WB_SW; b++) begin
                if (i_sel[b]) begin
                    regs[i_addr][8*b +: 8] <= i_wdata[8*b +: 8];
                end
            end
        end
    end

    // ack one cycle after every strobe
    always_ff @(posedge clk_i) begin
        if (!i_rst_n) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_stb;
        end
    end

    // old value on reads, zero on write acks
    always_ff @(posedge clk_i) begin
        if (i_stb && !i_we) begin
            o_rdata <= rd_word;
        end else begin
            o_rdata <= '0;
        end
    end

endmodule : wb_scratch_slave
